// ==== hw/mdu_op_pkg.sv ====
package mdu_op_pkg;

    typedef logic [31:0] word_t;   // Operand or result word.
    typedef logic [7:0]  tag_t;    // Decode tag, returned with the result.
    typedef logic [2:0]  op_t;

    // **************************************************
    // Operation codes
    // Bit 2 set means divide class.
    // Bit 0 set within the divide class means unsigned.
    // **************************************************
    localparam op_t OP_MUL   = 3'd0;   // Low word of signed product.
    localparam op_t OP_MULH  = 3'd1;   // High word, signed x signed.
    localparam op_t OP_MULHU = 3'd2;   // High word, unsigned x unsigned.

    localparam op_t OP_DIV   = 3'd4;
    localparam op_t OP_DIVU  = 3'd5;
    localparam op_t OP_MOD   = 3'd6;
    localparam op_t OP_MODU  = 3'd7;

    // Code 3'd3 is not used.

endpackage

// ==== hw/mdu_ctrl_pkg.sv ====
package mdu_ctrl_pkg;

    typedef logic [5:0] cnt_t;   // Iteration counter value.

    localparam cnt_t MUL_STAGES = 6'd2;    // Multiplier pipeline cycles.
    localparam cnt_t DIV_STEPS  = 6'd32;   // One quotient bit per step.

    // **************************************************
    // Controller states
    // **************************************************
    typedef enum logic [2:0] {
        ST_IDLE,   // Waiting for a request.
        ST_MUL,    // Multiplier pipeline running.
        ST_DIV,    // Divider iterating.
        ST_FIX,    // Sign correction of the divide result.
        ST_DONE    // Result held until taken.
    } ctrl_state_t;

endpackage

// ==== hw/mdu_ctrl_fsm.sv ====
`timescale 1ns/1ps

module mdu_ctrl_fsm (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               flush_i,
    input  logic               valid_i,
    input  logic               ready_i,
    input  mdu_op_pkg::op_t    op_i,
    input  logic               cnt_zero_i,
    output logic               ready_o,
    output logic               valid_o,
    output logic               mul_start_o,
    output logic               div_start_o,
    output logic               div_step_o,
    output logic               div_fix_o,
    output logic               cnt_load_o,
    output logic               res_sel_o,
    output mdu_ctrl_pkg::cnt_t cnt_val_o
);

    import mdu_ctrl_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        accept;
    logic        is_div;
    logic        res_sel_q;   // 1 selects the divider.

    assign accept    = valid_i && ready_o && !flush_i;
    assign is_div    = op_i[2];
    assign ready_o   = (state_q == ST_IDLE);
    assign valid_o   = (state_q == ST_DONE);
    assign res_sel_o = res_sel_q;
    // Divide keeps one spare ST_DIV cycle after its last step.
    assign cnt_val_o = is_div ? DIV_STEPS : cnt_t'(MUL_STAGES - 1);

    always_comb begin
        state_d     = state_q;
        mul_start_o = 1'b0;
        div_start_o = 1'b0;
        div_step_o  = 1'b0;
        div_fix_o   = 1'b0;
        cnt_load_o  = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    cnt_load_o  = 1'b1;
                    mul_start_o = !is_div;
                    div_start_o = is_div;
                    state_d     = is_div ? ST_DIV : ST_MUL;
                end
            end
            ST_MUL: begin
                if (cnt_zero_i) begin
                    state_d = ST_DONE;
                end
            end
            ST_DIV: begin
                div_step_o = !cnt_zero_i;
                if (cnt_zero_i) begin
                    state_d = ST_FIX;
                end
            end
            ST_FIX: begin
                div_fix_o = 1'b1;
                state_d   = ST_DONE;
            end
            ST_DONE: begin
                if (ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
        if (flush_i) begin
            state_d = ST_IDLE;   // Drop whatever is in flight.
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            res_sel_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                res_sel_q <= is_div;
            end
        end
    end

    // **************************************************
    // Assertions
    // **************************************************
    a_no_valid_with_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(valid_o && ready_o));

    a_single_start: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(mul_start_o && div_start_o));

endmodule

// ==== hw/mdu_iter_counter.sv ====
`timescale 1ns/1ps

module mdu_iter_counter (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               load_i,
    input  mdu_ctrl_pkg::cnt_t load_val_i,
    output logic               zero_o
);

    import mdu_ctrl_pkg::*;

    cnt_t cnt_q;

    // Down-counter, sticks at zero until the next load.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= load_val_i;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 6'd1;
        end
    end

    assign zero_o = (cnt_q == '0);

    // Longest phase is the divide with its spare cycle.
    a_cnt_in_range: assert property (@(posedge clk) disable iff (!arst_n_i)
        load_i |=> (cnt_q <= DIV_STEPS));

endmodule

// ==== hw/mdu_multiplier.sv ====
`timescale 1ns/1ps

module mdu_multiplier (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              start_i,
    input  mdu_op_pkg::op_t   op_i,
    input  mdu_op_pkg::word_t a_i,
    input  mdu_op_pkg::word_t b_i,
    output mdu_op_pkg::word_t res_o
);

    import mdu_op_pkg::*;

    logic               ext_sign;
    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [32:0] a_q;
    logic signed [32:0] b_q;
    op_t                op_q;
    logic               v1_q;      // Stage 1 holds a live operation.
    logic signed [65:0] prod;
    word_t              res_q;

    // MULHU takes both operands as unsigned.
    assign ext_sign = (op_i != OP_MULHU);
    assign a_ext    = {ext_sign & a_i[31], a_i};
    assign b_ext    = {ext_sign & b_i[31], b_i};

    // **************************************************
    // Stage 1, extended operands
    // **************************************************
    always_ff @(posedge clk) begin
        if (start_i) begin
            a_q  <= a_ext;
            b_q  <= b_ext;
            op_q <= op_i;
        end
    end

    assign prod = a_q * b_q;

    // **************************************************
    // Stage 2, product word
    // **************************************************
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            v1_q  <= 1'b0;
            res_q <= '0;
        end else begin
            v1_q <= start_i;
            if (v1_q) begin
                res_q <= (op_q == OP_MULH || op_q == OP_MULHU) ? prod[63:32] : prod[31:0];
            end
        end
    end

    assign res_o = res_q;

endmodule

// ==== hw/mdu_divider.sv ====
`timescale 1ns/1ps

module mdu_divider (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              start_i,
    input  logic              step_i,
    input  logic              fix_i,
    input  mdu_op_pkg::op_t   op_i,
    input  mdu_op_pkg::word_t a_i,
    input  mdu_op_pkg::word_t b_i,
    output mdu_op_pkg::word_t res_o
);

    import mdu_op_pkg::*;

    logic        is_signed;
    logic        a_neg;
    logic        b_neg;
    word_t       a_mag;
    word_t       b_mag;
    // Iteration state.
    word_t       quo_q;    // Dividend shifts out, quotient shifts in.
    word_t       rem_q;
    word_t       dvs_q;
    logic [32:0] shifted;
    logic [33:0] trial;
    // Captured at start for the fix cycle.
    word_t       a_q;
    logic        neg_quo_q;
    logic        neg_rem_q;
    logic        rem_sel_q;
    logic        div0_q;
    logic        ovf_q;
    word_t       quo_fix;
    word_t       rem_fix;
    word_t       res_q;

    assign is_signed = (op_i == OP_DIV || op_i == OP_MOD);
    assign a_neg     = is_signed & a_i[31];
    assign b_neg     = is_signed & b_i[31];
    assign a_mag     = a_neg ? (~a_i + 32'd1) : a_i;
    assign b_mag     = b_neg ? (~b_i + 32'd1) : b_i;

    // Trial subtraction; no borrow means quotient bit 1.
    assign shifted = {rem_q, quo_q[31]};
    assign trial   = {1'b0, shifted} - {2'b00, dvs_q};

    always_ff @(posedge clk) begin
        if (start_i) begin
            quo_q     <= a_mag;
            rem_q     <= '0;
            dvs_q     <= b_mag;
            a_q       <= a_i;
            neg_quo_q <= a_neg ^ b_neg;
            neg_rem_q <= a_neg;   // Remainder follows the dividend.
            rem_sel_q <= (op_i == OP_MOD || op_i == OP_MODU);
            div0_q    <= (b_i == '0);
            ovf_q     <= is_signed && (a_i == 32'h8000_0000) && (b_i == 32'hffff_ffff);
        end else if (step_i) begin
            if (!trial[33]) begin
                rem_q <= trial[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= shifted[31:0];
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    // **************************************************
    // Sign correction and special cases
    // **************************************************
    always_comb begin
        quo_fix = neg_quo_q ? (~quo_q + 32'd1) : quo_q;
        rem_fix = neg_rem_q ? (~rem_q + 32'd1) : rem_q;
        if (div0_q) begin
            quo_fix = '1;
            rem_fix = a_q;
        end else if (ovf_q) begin
            quo_fix = a_q;
            rem_fix = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_q <= '0;
        end else if (fix_i) begin
            res_q <= rem_sel_q ? rem_fix : quo_fix;
        end
    end

    assign res_o = res_q;

    a_no_step_on_start: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(step_i && start_i));

endmodule

// ==== hw/mdu_top.sv ====
`timescale 1ns/1ps

module mdu_top (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              flush_i,
    input  logic              valid_i,
    input  logic              ready_i,
    input  mdu_op_pkg::op_t   op_i,
    input  mdu_op_pkg::word_t a_i,
    input  mdu_op_pkg::word_t b_i,
    input  mdu_op_pkg::tag_t  tag_i,
    output logic              ready_o,
    output logic              valid_o,
    output mdu_op_pkg::word_t res_o,
    output mdu_op_pkg::tag_t  tag_o
);

    import mdu_op_pkg::*;
    import mdu_ctrl_pkg::*;

    logic  mul_start;
    logic  div_start;
    logic  div_step;
    logic  div_fix;
    logic  cnt_load;
    logic  cnt_zero;
    logic  res_sel;
    cnt_t  cnt_val;
    word_t mul_res;
    word_t div_res;
    tag_t  tag_q;

    mdu_ctrl_fsm i_mdu_ctrl_fsm (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .valid_i     (valid_i),
        .ready_i     (ready_i),
        .op_i        (op_i),
        .cnt_zero_i  (cnt_zero),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .mul_start_o (mul_start),
        .div_start_o (div_start),
        .div_step_o  (div_step),
        .div_fix_o   (div_fix),
        .cnt_load_o  (cnt_load),
        .res_sel_o   (res_sel),
        .cnt_val_o   (cnt_val)
    );

    mdu_iter_counter i_mdu_iter_counter (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .load_i     (cnt_load),
        .load_val_i (cnt_val),
        .zero_o     (cnt_zero)
    );

    mdu_multiplier i_mdu_multiplier (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (mul_start),
        .op_i     (op_i),
        .a_i      (a_i),
        .b_i      (b_i),
        .res_o    (mul_res)
    );

    mdu_divider i_mdu_divider (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (div_start),
        .step_i   (div_step),
        .fix_i    (div_fix),
        .op_i     (op_i),
        .a_i      (a_i),
        .b_i      (b_i),
        .res_o    (div_res)
    );

    // Tag rides alongside the accepted operation.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tag_q <= '0;
        end else if (valid_i && ready_o && !flush_i) begin
            tag_q <= tag_i;
        end
    end

    assign tag_o = tag_q;
    assign res_o = res_sel ? div_res : mul_res;

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    localparam real PERIOD_NS    = 8.0;
    localparam int  RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;   // In reset from time zero.
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 arst_n_o = 1'b1;
    end

endmodule

// ==== dv/tb_mdu.sv ====
`timescale 1ns/1ps

module tb_mdu;

    import mdu_op_pkg::*;
    import mdu_ctrl_pkg::*;

    localparam int N_MUL     = 300;
    localparam int N_DIV     = 300;
    localparam int N_BP      = 40;
    localparam int N_FLUSH   = 20;
    localparam int WD_CYCLES = (N_MUL + N_DIV + N_BP + 2 * N_FLUSH) * 40 + 500;

    logic        clk;
    logic        arst_n;
    logic        flush;
    logic        in_valid;
    logic        in_ready;
    logic        out_valid;
    logic        out_ready;
    op_t         op;
    word_t       opa;
    word_t       opb;
    tag_t        tag;
    word_t       res;
    tag_t        res_tag;
    logic [31:0] rng_state = 32'h29e3f57a;
    int          errors    = 0;

    tb_clk_gen i_tb_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    mdu_top i_mdu_top (
        .clk      (clk),
        .arst_n_i (arst_n),
        .flush_i  (flush),
        .valid_i  (in_valid),
        .ready_i  (out_ready),
        .op_i     (op),
        .a_i      (opa),
        .b_i      (opb),
        .tag_i    (tag),
        .ready_o  (in_ready),
        .valid_o  (out_valid),
        .res_o    (res),
        .tag_o    (res_tag)
    );

    // **************************************************
    // Random numbers and reference model
    // **************************************************
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rand32(output logic [31:0] r);
        logic [31:0] hi;
        rng_state = lcg_next(rng_state);
        hi        = rng_state;
        rng_state = lcg_next(rng_state);
        r         = {hi[31:16], rng_state[31:16]};   // Upper halves only.
    endtask

    task automatic rand_operand(output word_t v);
        logic [31:0] sel;
        logic [31:0] raw;
        rand32(sel);
        rand32(raw);
        case (sel[2:0])
            3'd0:    v = 32'h8000_0000;
            3'd1:    v = 32'hffff_ffff;
            3'd2:    v = 32'h7fff_ffff;
            3'd3:    v = {24'd0, raw[7:0]};
            default: v = raw;
        endcase
    endtask

    function automatic op_t pick_op(input logic [31:0] r, input logic div_class);
        op_t mul_ops [3] = '{OP_MUL, OP_MULH, OP_MULHU};
        op_t div_ops [4] = '{OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
        return div_class ? div_ops[r[1:0]] : mul_ops[r % 3];
    endfunction

    function automatic word_t model_result(input op_t o, input word_t a, input word_t b);
        logic signed [63:0] sp;
        logic        [63:0] up;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] sq;
        logic signed [31:0] sr;
        logic               ovf;
        sa  = a;
        sb  = b;
        sq  = '0;
        sr  = '0;
        sp  = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        up  = {32'd0, a} * {32'd0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        if (b != 0 && !ovf) begin
            sq = sa / sb;   // Truncates toward zero.
            sr = sa % sb;
        end
        case (o)
            OP_MUL:   return sp[31:0];
            OP_MULH:  return sp[63:32];
            OP_MULHU: return up[63:32];
            OP_DIV:   return (b == 0) ? 32'hffff_ffff : (ovf ? a : sq);
            OP_DIVU:  return (b == 0) ? 32'hffff_ffff : a / b;
            OP_MOD:   return (b == 0) ? a : (ovf ? 32'd0 : sr);
            OP_MODU:  return (b == 0) ? a : a % b;
            default:  return 32'd0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // **************************************************
    // Transactions
    // **************************************************
    // Returns 1 ns after the accepting edge.
    task automatic send_request(input op_t o, input word_t x, input word_t y, input tag_t t);
        op       = o;
        opa      = x;
        opb      = y;
        tag      = t;
        in_valid = 1'b1;
        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic run_op(input string name, input op_t o, input word_t x, input word_t y,
                          input tag_t t, input int hold);
        int    lat;
        int    exp_lat;
        word_t held_res;
        tag_t  held_tag;
        exp_lat   = o[2] ? int'(DIV_STEPS) + 2 : int'(MUL_STAGES);
        out_ready = (hold == 0);
        send_request(o, x, y, t);
        lat = 0;
        while (!out_valid) begin
            @(posedge clk);
            #1;
            lat++;
        end
        check_value({name, " latency"}, exp_lat, lat);
        check_value({name, " result"}, model_result(o, x, y), res);
        check_value({name, " tag"}, t, res_tag);
        held_res = res;
        held_tag = res_tag;
        repeat (hold) begin
            @(posedge clk);
            #1;
            check_value({name, " held valid_o"}, 1, out_valid);
            check_value({name, " held ready_o"}, 0, in_ready);
            check_value({name, " held result"}, held_res, res);
            check_value({name, " held tag"}, held_tag, res_tag);
        end
        out_ready = 1'b1;
        @(posedge clk);   // Result transfers here.
        #1;
        check_value({name, " valid_o after transfer"}, 0, out_valid);
        check_value({name, " ready_o after transfer"}, 1, in_ready);
    endtask

    task automatic run_flush(input int idx);
        logic [31:0] r;
        word_t       x;
        word_t       y;
        rand_operand(x);
        rand_operand(y);
        rand32(r);
        out_ready = 1'b1;
        send_request(pick_op(r, 1'b1), x, y, r[15:8]);
        repeat (r[20:16] % 30) begin   // Stay inside the divide phase.
            @(posedge clk);
            #1;
        end
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        check_value($sformatf("flush %0d valid_o", idx), 0, out_valid);
        check_value($sformatf("flush %0d ready_o", idx), 1, in_ready);
        rand_operand(x);
        rand_operand(y);
        run_op($sformatf("flush %0d follow-up", idx), pick_op(r >> 8, 1'b0), x, y,
               ~r[15:8], 0);
    endtask

    // **************************************************
    // Test sequence
    // **************************************************
    initial begin
        logic [31:0] r;
        word_t       x;
        word_t       y;
        op_t         o;
        flush     = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        op        = OP_MUL;
        opa       = '0;
        opb       = '0;
        tag       = '0;
        @(posedge arst_n);
        @(posedge clk);
        #1;
        check_value("reset valid_o", 0, out_valid);
        check_value("reset ready_o", 1, in_ready);
        check_value("reset tag_o", 0, res_tag);
        check_value("reset res_o", 0, res);
        for (int i = 0; i < N_MUL; i++) begin
            rand_operand(x);
            rand_operand(y);
            rand32(r);
            run_op($sformatf("mul %0d", i), pick_op(r, 1'b0), x, y, r[23:16], 0);
        end
        for (int i = 0; i < N_DIV; i++) begin
            rand_operand(x);
            rand_operand(y);
            rand32(r);
            o = pick_op(r, 1'b1);
            if (i % 10 == 3) begin
                y = '0;
            end else if (i % 10 == 7) begin
                x = 32'h8000_0000;   // Signed overflow case.
                y = 32'hffff_ffff;
                o = r[2] ? OP_DIV : OP_MOD;
            end
            run_op($sformatf("div %0d", i), o, x, y, r[23:16], 0);
        end
        for (int i = 0; i < N_BP; i++) begin
            rand_operand(x);
            rand_operand(y);
            rand32(r);
            run_op($sformatf("backpressure %0d", i), pick_op(r, r[8]), x, y, r[23:16],
                   r[30:28]);
        end
        for (int i = 0; i < N_FLUSH; i++) begin
            run_flush(i);
        end
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout: DUT stopped responding");
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== mdu.f ====
hw/mdu_op_pkg.sv
hw/mdu_ctrl_pkg.sv
hw/mdu_ctrl_fsm.sv
hw/mdu_iter_counter.sv
hw/mdu_multiplier.sv
hw/mdu_divider.sv
hw/mdu_top.sv
dv/tb_clk_gen.sv
dv/tb_mdu.sv
